/* hdl/lsu_op_pkg.sv */
// load/store unit operation definitions
// opcodes, access sizes and datapath widths shared by the
// address generation, data alignment and control blocks

package lsu_op_pkg;

  // ------------------------------
  // datapath widths
  // ------------------------------
  localparam int unsigned XLEN = 32;
  localparam int unsigned BE_W = XLEN / 8;

  // writeback tag, one per scoreboard slot
  localparam int unsigned TRANS_ID_W = 3;

  // ------------------------------
  // operations
  // ------------------------------
  // loads sit in the lower half of the code space, stores above
  typedef enum logic [3:0] {
    LB  = 4'h0,
    LBU = 4'h1,
    LH  = 4'h2,
    LHU = 4'h3,
    LW  = 4'h4,
    SB  = 4'h8,
    SH  = 4'h9,
    SW  = 4'hA
  } lsu_op_e;

  // ------------------------------
  // access size
  // ------------------------------
  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } size_e;

endpackage

/* hdl/lsu_bus_pkg.sv */
// load/store unit memory-side definitions
// APB widths and the exception causes reported on writeback

package lsu_bus_pkg;

  // APB master port
  localparam int unsigned APB_AW = 32;
  localparam int unsigned APB_DW = 32;
  // one strobe bit per data byte
  localparam int unsigned APB_SW = APB_DW / 8;

  // ------------------------------
  // exception causes
  // ------------------------------
  // values follow the RISC-V mcause encoding
  typedef enum logic [3:0] {
    NONE               = 4'd0,
    LD_ADDR_MISALIGNED = 4'd4,
    LD_ACCESS_FAULT    = 4'd5,
    ST_ADDR_MISALIGNED = 4'd6,
    ST_ACCESS_FAULT    = 4'd7
  } exc_cause_e;

endpackage

/* hdl/lsu_agu.sv */
// load/store address generation unit
// forms the effective address, the byte enables and the
// misalignment flag, all combinationally from the request

`timescale 1ns/1ps

module lsu_agu
  import lsu_op_pkg::*;
(
  input  lsu_op_e         op_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] imm_i,
  output logic [XLEN-1:0] vaddr_o,
  output logic [BE_W-1:0] be_o,
  output logic            misaligned_o
);

  size_e           size;
  logic [BE_W-1:0] size_mask;

  // immediate already arrives sign-extended to XLEN
  assign vaddr_o = $unsigned($signed(operand_a_i) + $signed(imm_i));

  // ------------------------------
  // access size decode
  // ------------------------------
  always_comb begin
    unique case (op_i)
      LB, LBU, SB: size = BYTE;
      LH, LHU, SH: size = HALF;
      default:     size = WORD;
    endcase
  end

  always_comb begin
    unique case (size)
      BYTE:    size_mask = 4'b0001;
      HALF:    size_mask = 4'b0011;
      default: size_mask = 4'b1111;
    endcase
  end

  // lanes move up with the low address bits
  assign be_o = size_mask << vaddr_o[1:0];

  // ------------------------------
  // misalignment
  // ------------------------------
  // bytes are always aligned
  always_comb begin
    unique case (size)
      HALF:    misaligned_o = vaddr_o[0];
      WORD:    misaligned_o = |vaddr_o[1:0];
      default: misaligned_o = 1'b0;
    endcase
  end

endmodule

/* hdl/lsu_data_align.sv */
// load/store data alignment
// moves store data into its byte lanes and pulls load data out
// of its lane with sign or zero extension

`timescale 1ns/1ps

module lsu_data_align
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;
(
  input  lsu_op_e           op_i,
  input  logic [1:0]        offset_i,
  input  logic [XLEN-1:0]   store_data_i,
  input  logic [APB_DW-1:0] prdata_i,
  output logic [APB_DW-1:0] pwdata_o,
  output logic [XLEN-1:0]   load_data_o
);

  logic [4:0]        lane_shift;
  logic [APB_DW-1:0] rdata_shifted;
  logic [7:0]        rd_byte;
  logic [15:0]       rd_half;

  // byte offset to bit offset
  assign lane_shift = {offset_i, 3'b000};

  // ------------------------------
  // store path
  // ------------------------------
  always_comb begin
    unique case (op_i)
      SB:      pwdata_o = {24'b0, store_data_i[7:0]} << lane_shift;
      SH:      pwdata_o = {16'b0, store_data_i[15:0]} << lane_shift;
      default: pwdata_o = store_data_i;
    endcase
  end

  // ------------------------------
  // load path
  // ------------------------------
  // bring the addressed lane down to bit 0
  assign rdata_shifted = prdata_i >> lane_shift;
  assign rd_byte       = rdata_shifted[7:0];
  assign rd_half       = rdata_shifted[15:0];

  always_comb begin
    unique case (op_i)
      LB:      load_data_o = {{(XLEN-8){rd_byte[7]}}, rd_byte};
      LBU:     load_data_o = {{(XLEN-8){1'b0}}, rd_byte};
      LH:      load_data_o = {{(XLEN-16){rd_half[15]}}, rd_half};
      LHU:     load_data_o = {{(XLEN-16){1'b0}}, rd_half};
      // word passes straight through
      default: load_data_o = prdata_i;
    endcase
  end

endmodule

/* hdl/lsu_ctrl.sv */
// load/store controller
// holds the accepted request, runs one APB transfer at a time
// and returns the result on the load or store writeback channel

`timescale 1ns/1ps

module lsu_ctrl
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // request side
  input  logic                  valid_i,
  output logic                  ready_o,
  input  lsu_op_e               op_i,
  input  logic [TRANS_ID_W-1:0] trans_id_i,
  input  logic [XLEN-1:0]       store_data_i,
  // from the AGU
  input  logic [XLEN-1:0]       vaddr_i,
  input  logic [BE_W-1:0]       be_i,
  input  logic                  misaligned_i,
  // to and from the data alignment
  output lsu_op_e               op_q_o,
  output logic [1:0]            offset_q_o,
  output logic [XLEN-1:0]       store_data_q_o,
  input  logic [XLEN-1:0]       load_data_i,
  // APB master
  output logic                  psel_o,
  output logic                  penable_o,
  output logic                  pwrite_o,
  output logic [APB_AW-1:0]     paddr_o,
  output logic [APB_SW-1:0]     pstrb_o,
  input  logic                  pready_i,
  input  logic                  pslverr_i,
  // writeback
  output logic                  load_valid_o,
  output logic [TRANS_ID_W-1:0] load_trans_id_o,
  output logic [XLEN-1:0]       load_result_o,
  output exc_cause_e            load_ex_o,
  output logic                  store_valid_o,
  output logic [TRANS_ID_W-1:0] store_trans_id_o,
  output exc_cause_e            store_ex_o
);

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS, RESP} state_e;

  state_e                state_q, state_d;
  lsu_op_e               op_q;
  logic [XLEN-1:0]       addr_q;
  logic [BE_W-1:0]       be_q;
  logic [XLEN-1:0]       data_q;
  logic [TRANS_ID_W-1:0] id_q;
  logic [XLEN-1:0]       result_q;
  exc_cause_e            ex_q;
  logic                  req_accept;
  logic                  xfer_done;
  logic                  store_q;

  function automatic logic is_store(lsu_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

  // RESP also takes a new request, so back-to-back ops lose no cycle
  assign ready_o    = (state_q == IDLE) || (state_q == RESP);
  assign req_accept = valid_i && ready_o;
  assign xfer_done  = (state_q == ACCESS) && pready_i;
  assign store_q    = is_store(op_q);

  // ------------------------------
  // state machine
  // ------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE, RESP: begin
        if (valid_i) begin
          // misaligned ops never reach the bus
          state_d = misaligned_i ? RESP : SETUP;
        end else begin
          state_d = IDLE;
        end
      end
      SETUP:   state_d = ACCESS;
      ACCESS:  state_d = pready_i ? RESP : ACCESS;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------
  // request and result registers
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      op_q     <= op_i;
      addr_q   <= vaddr_i;
      be_q     <= be_i;
      data_q   <= store_data_i;
      id_q     <= trans_id_i;
      result_q <= '0;
      if (misaligned_i) begin
        ex_q <= is_store(op_i) ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
      end else begin
        ex_q <= NONE;
      end
    end else if (xfer_done) begin
      if (pslverr_i) begin
        ex_q <= store_q ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
      end else begin
        result_q <= load_data_i;
      end
    end
  end

  assign op_q_o         = op_q;
  assign offset_q_o     = addr_q[1:0];
  assign store_data_q_o = data_q;

  // ------------------------------
  // APB outputs
  // ------------------------------
  assign psel_o    = (state_q == SETUP) || (state_q == ACCESS);
  assign penable_o = (state_q == ACCESS);
  assign pwrite_o  = store_q;
  assign paddr_o   = addr_q;
  // no strobes on reads
  assign pstrb_o   = store_q ? be_q : '0;

  // ------------------------------
  // writeback
  // ------------------------------
  assign load_valid_o     = (state_q == RESP) && !store_q;
  assign load_trans_id_o  = id_q;
  assign load_result_o    = result_q;
  assign load_ex_o        = ex_q;

  assign store_valid_o    = (state_q == RESP) && store_q;
  assign store_trans_id_o = id_q;
  assign store_ex_o       = ex_q;

endmodule

/* hdl/lsu_top.sv */
// load/store unit top level
// address generation, data alignment and the APB controller

`timescale 1ns/1ps

module lsu_top
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // request side
  input  logic                  valid_i,
  output logic                  ready_o,
  input  lsu_op_e               op_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       imm_i,
  input  logic [XLEN-1:0]       store_data_i,
  input  logic [TRANS_ID_W-1:0] trans_id_i,
  // APB master
  output logic                  psel_o,
  output logic                  penable_o,
  output logic                  pwrite_o,
  output logic [APB_AW-1:0]     paddr_o,
  output logic [APB_DW-1:0]     pwdata_o,
  output logic [APB_SW-1:0]     pstrb_o,
  input  logic [APB_DW-1:0]     prdata_i,
  input  logic                  pready_i,
  input  logic                  pslverr_i,
  // writeback
  output logic                  load_valid_o,
  output logic [TRANS_ID_W-1:0] load_trans_id_o,
  output logic [XLEN-1:0]       load_result_o,
  output exc_cause_e            load_ex_o,
  output logic                  store_valid_o,
  output logic [TRANS_ID_W-1:0] store_trans_id_o,
  output exc_cause_e            store_ex_o
);

  logic [XLEN-1:0] vaddr;
  logic [BE_W-1:0] be;
  logic            misaligned;
  lsu_op_e         op_q;
  logic [1:0]      offset_q;
  logic [XLEN-1:0] store_data_q;
  logic [XLEN-1:0] load_data;

  lsu_agu lsu_agu_i (
    .op_i         (op_i),
    .operand_a_i  (operand_a_i),
    .imm_i        (imm_i),
    .vaddr_o      (vaddr),
    .be_o         (be),
    .misaligned_o (misaligned)
  );

  // works on the registered op so the bus data stays stable
  lsu_data_align lsu_data_align_i (
    .op_i         (op_q),
    .offset_i     (offset_q),
    .store_data_i (store_data_q),
    .prdata_i     (prdata_i),
    .pwdata_o     (pwdata_o),
    .load_data_o  (load_data)
  );

  lsu_ctrl lsu_ctrl_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .valid_i          (valid_i),
    .ready_o          (ready_o),
    .op_i             (op_i),
    .trans_id_i       (trans_id_i),
    .store_data_i     (store_data_i),
    .vaddr_i          (vaddr),
    .be_i             (be),
    .misaligned_i     (misaligned),
    .op_q_o           (op_q),
    .offset_q_o       (offset_q),
    .store_data_q_o   (store_data_q),
    .load_data_i      (load_data),
    .psel_o           (psel_o),
    .penable_o        (penable_o),
    .pwrite_o         (pwrite_o),
    .paddr_o          (paddr_o),
    .pstrb_o          (pstrb_o),
    .pready_i         (pready_i),
    .pslverr_i        (pslverr_i),
    .load_valid_o     (load_valid_o),
    .load_trans_id_o  (load_trans_id_o),
    .load_result_o    (load_result_o),
    .load_ex_o        (load_ex_o),
    .store_valid_o    (store_valid_o),
    .store_trans_id_o (store_trans_id_o),
    .store_ex_o       (store_ex_o)
  );

endmodule

/* sim/lsu_asserts.sv */
// APB protocol and request handshake properties
// bound into the load/store controller

`timescale 1ns/1ps

module lsu_asserts
  import lsu_bus_pkg::*;
(
  input logic              clk_i,
  input logic              rst_ni,
  input logic              psel_i,
  input logic              penable_i,
  input logic              pwrite_i,
  input logic [APB_AW-1:0] paddr_i,
  input logic [APB_SW-1:0] pstrb_i,
  input logic              pready_i,
  input logic              ready_i
);

  int unsigned fail_cnt = 0;

  // ACCESS only ever follows SETUP
  a_penable_psel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    penable_i |-> psel_i)
    else begin
      fail_cnt++;
      $error("penable high without psel");
    end

  // transfer attributes held until pready ends the access
  a_apb_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    psel_i && !(penable_i && pready_i)
      |=> $stable(paddr_i) && $stable(pwrite_i) && $stable(pstrb_i))
    else begin
      fail_cnt++;
      $error("paddr, pwrite or pstrb changed during a transfer");
    end

  a_busy_not_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    psel_i |-> !ready_i)
    else begin
      fail_cnt++;
      $error("request side ready while a transfer is on the bus");
    end

endmodule

bind lsu_ctrl lsu_asserts lsu_asserts_i (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .psel_i    (psel_o),
  .penable_i (penable_o),
  .pwrite_i  (pwrite_o),
  .paddr_i   (paddr_o),
  .pstrb_i   (pstrb_o),
  .pready_i  (pready_i),
  .ready_i   (ready_o)
);

/* sim/tb_lsu.sv */
// load/store unit testbench
// directed tests against an APB slave memory model and a shadow copy
// of that memory that predicts every load result and store effect

`timescale 1ns/1ps

module tb_lsu
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;
;

  localparam int MEM_BYTES = 1024;
  localparam int MEM_AW = 10;
  localparam int MAX_WAIT = 3;
  localparam int SEED = 47;
  localparam int N_RAND = 20;
  // 27 directed operations plus the random ones
  localparam int N_OPS = 27 + N_RAND;
  localparam int TIMEOUT_CYCLES = N_OPS * (MAX_WAIT + 5) + 50;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  valid_i;
  logic                  ready_o;
  lsu_op_e               op_i;
  logic [XLEN-1:0]       operand_a_i;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       store_data_i;
  logic [TRANS_ID_W-1:0] trans_id_i;
  logic                  psel_o;
  logic                  penable_o;
  logic                  pwrite_o;
  logic [APB_AW-1:0]     paddr_o;
  logic [APB_DW-1:0]     pwdata_o;
  logic [APB_SW-1:0]     pstrb_o;
  logic [APB_DW-1:0]     prdata_i;
  logic                  pready_i;
  logic                  pslverr_i;
  logic                  load_valid_o;
  logic [TRANS_ID_W-1:0] load_trans_id_o;
  logic [XLEN-1:0]       load_result_o;
  exc_cause_e            load_ex_o;
  logic                  store_valid_o;
  logic [TRANS_ID_W-1:0] store_trans_id_o;
  exc_cause_e            store_ex_o;

  logic [7:0]            mem [MEM_BYTES];
  logic [7:0]            shadow [MEM_BYTES];
  logic [TRANS_ID_W-1:0] next_id;
  logic [XLEN-1:0]       exp_paddr;
  logic                  exp_pwrite;
  int                    value_errs;
  int                    other_errs;
  int                    wait_left;
  int                    cycles = 0;
  int                    wb_count = 0;
  int                    psel_cycles = 0;

  lsu_top lsu_top_i (.*);

  always #50 clk_i = ~clk_i;

  // ------------------------------
  // monitors and timeout
  // ------------------------------
  always @(posedge clk_i) begin
    if (load_valid_o || store_valid_o) begin
      wb_count++;
    end
    if (psel_o) begin
      psel_cycles++;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles, a writeback never arrived", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------
  // mixes high and low address bits so aliasing shows up
  function automatic logic [7:0] fill_byte(input int unsigned addr);
    logic [31:0] mix;
    mix = (addr * 32'd13) ^ (addr >> 8) ^ 32'h5a;
    return mix[7:0];
  endfunction

  function automatic logic [APB_DW-1:0] mem_word(input logic [APB_AW-1:0] addr);
    logic [APB_DW-1:0] w;
    for (int k = 0; k < 4; k++) begin
      w[8*k +: 8] = mem[{addr[MEM_AW-1:2], 2'b00} + MEM_AW'(k)];
    end
    return w;
  endfunction

  function automatic int size_bytes(input lsu_op_e op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      default:     return 4;
    endcase
  endfunction

  function automatic logic is_store_op(input lsu_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

  // little-endian lanes with extension by opcode
  function automatic logic [XLEN-1:0] predict_load(input lsu_op_e op,
                                                   input logic [XLEN-1:0] addr);
    logic [MEM_AW-1:0] idx;
    logic [7:0]        b;
    logic [15:0]       h;
    idx = addr[MEM_AW-1:0];
    b = shadow[idx];
    h = {shadow[idx + MEM_AW'(1)], shadow[idx]};
    case (op)
      LB:      return {{24{b[7]}}, b};
      LBU:     return {24'b0, b};
      LH:      return {{16{h[15]}}, h};
      LHU:     return {16'b0, h};
      default: return {shadow[idx + MEM_AW'(3)], shadow[idx + MEM_AW'(2)], h};
    endcase
  endfunction

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("** Error at %0d ns: %s expected 0x%h, got 0x%h", $time, name, exp, act);
    end
  endtask

  task automatic check_cause(input string name, input exc_cause_e exp, input exc_cause_e act);
    if (act !== exp) begin
      value_errs++;
      $display("** Error at %0d ns: %s expected %s, got %s", $time, name, exp.name(),
               act.name());
    end
  endtask

  task automatic check_id(input string name, input logic [TRANS_ID_W-1:0] exp,
                          input logic [TRANS_ID_W-1:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("** Error at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_memory();
    logic [XLEN-1:0] exp_w;
    for (int wa = 0; wa < MEM_BYTES; wa += 4) begin
      for (int k = 0; k < 4; k++) begin
        exp_w[8*k +: 8] = shadow[wa[MEM_AW-1:0] + MEM_AW'(k)];
      end
      check_data($sformatf("mem[0x%03h]", wa), exp_w, mem_word(XLEN'(wa)));
    end
  endtask

  // ------------------------------
  // one request, start to writeback
  // ------------------------------
  // called and returns 10 ns after a rising edge
  task automatic do_op(input lsu_op_e op, input logic [XLEN-1:0] a,
                       input logic [XLEN-1:0] imm, input logic [XLEN-1:0] data);
    logic [XLEN-1:0]       addr;
    logic [XLEN-1:0]       exp_res;
    logic [TRANS_ID_W-1:0] id;
    exc_cause_e            exp_ex;
    logic                  store;
    logic                  mis;
    logic                  fault;
    int                    nbytes;
    int                    wb_before;
    int                    psel_before;
    addr = a + imm;
    nbytes = size_bytes(op);
    store = is_store_op(op);
    mis = (int'(addr[1:0]) % nbytes) != 0;
    fault = !mis && (addr >= XLEN'(MEM_BYTES));
    id = next_id;
    next_id = next_id + 1'b1;
    exp_res = '0;
    if (mis) begin
      exp_ex = store ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
    end else if (fault) begin
      exp_ex = store ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
    end else begin
      exp_ex = NONE;
      if (store) begin
        for (int k = 0; k < nbytes; k++) begin
          shadow[addr[MEM_AW-1:0] + MEM_AW'(k)] = data[8*k +: 8];
        end
      end else begin
        exp_res = predict_load(op, addr);
      end
    end
    if (!ready_o) begin
      other_errs++;
      $display("ready_o was low at %0d ns when a new request was due", $time);
    end
    wb_before = wb_count;
    psel_before = psel_cycles;
    exp_paddr = addr;
    exp_pwrite = store;
    op_i = op;
    operand_a_i = a;
    imm_i = imm;
    store_data_i = data;
    trans_id_i = id;
    valid_i = 1'b1;
    @(posedge clk_i);
    #10;
    valid_i = 1'b0;
    @(negedge clk_i);
    while (!(load_valid_o || store_valid_o)) begin
      if (ready_o) begin
        other_errs++;
        $display("ready_o went high at %0d ns before the writeback", $time);
      end
      @(negedge clk_i);
    end
    if (store) begin
      check_data("store_valid_o", XLEN'(1'b1), XLEN'(store_valid_o));
      check_data("load_valid_o", '0, XLEN'(load_valid_o));
      check_id("store_trans_id_o", id, store_trans_id_o);
      check_cause("store_ex_o", exp_ex, store_ex_o);
    end else begin
      check_data("load_valid_o", XLEN'(1'b1), XLEN'(load_valid_o));
      check_data("store_valid_o", '0, XLEN'(store_valid_o));
      check_id("load_trans_id_o", id, load_trans_id_o);
      check_cause("load_ex_o", exp_ex, load_ex_o);
      if (!mis) begin
        check_data("load_result_o", exp_res, load_result_o);
      end
    end
    if (mis && (psel_cycles != psel_before)) begin
      other_errs++;
      $display("psel_o rose during a misaligned access at %0d ns", $time);
    end
    @(posedge clk_i);
    #10;
    if (wb_count != wb_before + 1) begin
      other_errs++;
      $display("trans_id %0d gave %0d writebacks instead of one", id, wb_count - wb_before);
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_reset_state();
    @(negedge clk_i);
    check_data("ready_o", XLEN'(1'b1), XLEN'(ready_o));
    check_data("psel_o", '0, XLEN'(psel_o));
    check_data("load_valid_o", '0, XLEN'(load_valid_o));
    check_data("store_valid_o", '0, XLEN'(store_valid_o));
    @(posedge clk_i);
    #10;
  endtask

  task automatic test_word_round_trip();
    logic [XLEN-1:0] data;
    data = $urandom;
    // 0x120 - 16 and 0x108 + 8 both land on 0x110
    do_op(SW, 32'h120, 32'hFFFF_FFF0, data);
    do_op(LW, 32'h108, 32'h8, '0);
    check_data("load_result_o", data, load_result_o);
    check_memory();
  endtask

  task automatic test_subword();
    logic [XLEN-1:0] data;
    for (int off = 0; off < 4; off++) begin
      data = $urandom;
      data[7] = off[0];
      do_op(SB, 32'h200, XLEN'(off), data);
      do_op(LB, 32'h200, XLEN'(off), '0);
      do_op(LBU, 32'h200, XLEN'(off), '0);
    end
    for (int off = 0; off < 4; off += 2) begin
      data = $urandom;
      data[15] = off[1];
      do_op(SH, 32'h240, XLEN'(off), data);
      do_op(LH, 32'h240, XLEN'(off), '0);
      do_op(LHU, 32'h240, XLEN'(off), '0);
    end
    check_memory();
  endtask

  task automatic test_misaligned();
    do_op(LH, 32'h301, '0, '0);
    for (int off = 1; off < 4; off++) begin
      do_op(SW, 32'h300, XLEN'(off), $urandom);
    end
    check_memory();
  endtask

  task automatic test_bus_error();
    do_op(LW, XLEN'(MEM_BYTES), '0, '0);
    do_op(SW, XLEN'(MEM_BYTES) + 32'h100, 32'hFFFF_FFFC, $urandom);
    do_op(LB, 32'h8000_0000, 32'h3, '0);
    check_memory();
  endtask

  task automatic test_wait_states();
    lsu_op_e         op;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] imm;
    int unsigned     sel;
    for (int n = 0; n < N_RAND; n++) begin
      sel = $urandom % 8;
      case (sel)
        0:       op = LB;
        1:       op = LBU;
        2:       op = LH;
        3:       op = LHU;
        4:       op = LW;
        5:       op = SB;
        6:       op = SH;
        default: op = SW;
      endcase
      addr = $urandom % MEM_BYTES;
      addr = addr & ~XLEN'(size_bytes(op) - 1);
      imm = XLEN'($urandom % 128) - XLEN'(64);
      do_op(op, addr - imm, imm, $urandom);
    end
    check_memory();
  endtask

  // ------------------------------
  // APB slave memory model
  // ------------------------------
  initial begin
    pready_i = 1'b0;
    pslverr_i = 1'b0;
    prdata_i = '0;
    wait_left = 0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i[MEM_AW-1:0]] = fill_byte(i);
    end
    forever begin
      @(posedge clk_i);
      if (psel_o && penable_o && pready_i && pwrite_o && !pslverr_i) begin
        for (int k = 0; k < APB_SW; k++) begin
          if (pstrb_o[k]) begin
            mem[{paddr_o[MEM_AW-1:2], 2'b00} + MEM_AW'(k)] = pwdata_o[8*k +: 8];
          end
        end
      end
      // wait states picked as SETUP hands over to ACCESS
      if (psel_o && !penable_o) begin
        // full byte address and direction, no strobes on reads
        check_data("paddr_o", exp_paddr, paddr_o);
        check_data("pwrite_o", XLEN'(exp_pwrite), XLEN'(pwrite_o));
        if (!exp_pwrite) begin
          check_data("pstrb_o", '0, XLEN'(pstrb_o));
        end
        wait_left = $urandom % (MAX_WAIT + 1);
      end else if (psel_o && penable_o && !pready_i && wait_left > 0) begin
        wait_left = wait_left - 1;
      end
      #10;
      if (psel_o && penable_o) begin
        pready_i = (wait_left == 0);
        pslverr_i = (wait_left == 0) && (paddr_o >= APB_AW'(MEM_BYTES));
        prdata_i = mem_word(paddr_o);
      end else begin
        pready_i = 1'b0;
        pslverr_i = 1'b0;
        prdata_i = '0;
      end
    end
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    void'($urandom(SEED));
    value_errs = 0;
    other_errs = 0;
    next_id = '0;
    exp_paddr = '0;
    exp_pwrite = 1'b0;
    rst_ni = 1'b0;
    valid_i = 1'b0;
    op_i = LB;
    operand_a_i = '0;
    imm_i = '0;
    store_data_i = '0;
    trans_id_i = '0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      shadow[i[MEM_AW-1:0]] = fill_byte(i);
    end
    repeat (3) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    test_reset_state();
    test_word_round_trip();
    test_subword();
    test_misaligned();
    test_bus_error();
    test_wait_states();
    other_errs += int'(lsu_top_i.lsu_ctrl_i.lsu_asserts_i.fail_cnt);
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
hdl/lsu_op_pkg.sv
hdl/lsu_bus_pkg.sv
hdl/lsu_agu.sv
hdl/lsu_data_align.sv
hdl/lsu_ctrl.sv
hdl/lsu_top.sv
sim/lsu_asserts.sv
sim/tb_lsu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lsu
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIMFLAGS  ?= +verilator+error+limit+100
SRCS      := $(shell cat $(FLIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Test OK" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
